//--- design/clut_grey.sv
/* colour lookup table, 16 entries of 4 bits per channel
   contents fixed at elaboration from the palette data file */
`timescale 1ns/1ps

module clut_grey import fb_pkg::*; (
    input  logic   clk_pix,
    input  cidx_t  cidx,   // colour index in
    output colr_t  colr    // {r, g, b} the cycle after
);

    // ROM, one colour per index
    colr_t pal [2**CIDX_W];

    initial begin
        $readmemh(PAL_FILE, pal);  // 12-bit hex per line
    end

    // registered lookup
    always_ff @(posedge clk_pix) begin
        colr <= pal[cidx];
    end

endmodule

//--- design/display_timing.sv
/* raster counters for the 80x54 mode, with data enable and strobes
   sx runs -16..63 and sy -6..47, negative values are blanking */
`timescale 1ns/1ps

module display_timing import fb_pkg::*; (
    input  logic   clk_pix,
    input  logic   rst_n,
    output coord_t sx,     // horizontal position
    output coord_t sy,     // vertical position
    output logic   de,     // high in the active area
    output logic   frame,  // one cycle at the first blanking pixel of a frame
    output logic   line    // one cycle at the start of every line
);

    localparam coord_t SX_FIRST = coord_t'(H_START);
    localparam coord_t SX_LAST  = coord_t'(H_ACTIVE - 1);
    localparam coord_t SY_FIRST = coord_t'(V_START);
    localparam coord_t SY_LAST  = coord_t'(V_ACTIVE - 1);

    // horizontal counter, vertical steps on its wrap
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            sx <= SX_FIRST;
            sy <= SY_FIRST;
        end else begin
            if (sx == SX_LAST) begin
                sx <= SX_FIRST;  // new line
                if (sy == SY_LAST) begin
                    sy <= SY_FIRST;  // new frame
                end else begin
                    sy <= sy + coord_t'(1);
                end
            end else begin
                sx <= sx + coord_t'(1);
            end
        end
    end

    // decoded flags, same cycle as the coordinates
    always_comb begin
        de    = (sx >= 0) && (sy >= 0);
        line  = (sx == SX_FIRST);
        frame = (sx == SX_FIRST) && (sy == SY_FIRST);
    end

endmodule

//--- design/fb_arbiter.sv
/* shares the framebuffer between the linebuffer fill reads and the pixel writer
   reads always win; a colliding write waits one slot in a holding register */
`timescale 1ns/1ps

module fb_arbiter import fb_pkg::*; (
    input  logic     clk_pix,
    input  logic     rst_n,
    input  logic     rd_req,     // fill read, never refused
    input  fb_addr_t rd_addr,
    output cidx_t    rd_data,    // two cycles after rd_req
    input  logic     wr_stb,     // single-cycle write strobe
    input  fb_addr_t wr_addr,
    input  cidx_t    wr_cidx,
    output logic     mem_we,
    output fb_addr_t mem_waddr,
    output cidx_t    mem_wdata,
    output fb_addr_t mem_raddr,
    input  cidx_t    mem_rdata   // one cycle after mem_raddr
);

    logic     pend_vld;   // write waiting for a free slot
    fb_addr_t pend_addr;
    cidx_t    pend_cidx;

    // read address goes straight through
    assign mem_raddr = rd_addr;

    // write port free whenever no read this cycle, held write first
    always_comb begin
        mem_we    = !rd_req && (pend_vld || wr_stb);
        mem_waddr = pend_vld ? pend_addr : wr_addr;
        mem_wdata = pend_vld ? pend_cidx : wr_cidx;
    end

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            pend_vld <= 1'b0;
        end else if (wr_stb && rd_req) begin
            pend_vld <= 1'b1;  // collided with a read
        end else if (!rd_req) begin
            pend_vld <= 1'b0;  // issued this cycle
        end
    end

    // capture the colliding write
    always_ff @(posedge clk_pix) begin
        if (wr_stb && rd_req) begin
            pend_addr <= wr_addr;
            pend_cidx <= wr_cidx;
        end
    end

    // extra stage gives the fixed two-cycle read latency
    always_ff @(posedge clk_pix) begin
        rd_data <= mem_rdata;
    end

    // writer spacing plus fill cadence keep the holding slot from overflowing
    a_pend_no_overflow : assert property (
        @(posedge clk_pix) disable iff (!rst_n) pend_vld |-> !wr_stb
    ) else $error("fb_arbiter: write strobe while a write is still held");

    // fill engine leaves a gap after every read
    a_read_spacing : assert property (
        @(posedge clk_pix) disable iff (!rst_n) rd_req |=> !rd_req
    ) else $error("fb_arbiter: back-to-back fill reads");

endmodule

//--- design/fb_bram.sv
/* simple dual-port framebuffer store, one write and one read port
   read data is registered, so it appears one cycle after raddr */
`timescale 1ns/1ps

module fb_bram import fb_pkg::*; (
    input  logic     clk_pix,
    input  logic     we,     // write strobe
    input  fb_addr_t waddr,
    input  cidx_t    wdata,
    input  fb_addr_t raddr,
    output cidx_t    rdata   // valid the cycle after raddr
);

    // block RAM style array, contents undefined at power up
    cidx_t mem [FB_PIXELS];

    always_ff @(posedge clk_pix) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // read before write on a shared address, old data comes out
    always_ff @(posedge clk_pix) begin
        rdata <= mem[raddr];
    end

endmodule

//--- design/fb_display_top.sv
/* scaled framebuffer display: timing, shared memory, linebuffer and palette
   drive wr_* to paint pixels; vid_* carry one aligned pixel per clock */
`timescale 1ns/1ps

module fb_display_top import fb_pkg::*; (
    input  logic              clk_pix,
    input  logic              rst_n,
    input  logic              wr_stb,     // one-cycle write strobe
    input  fb_addr_t          wr_addr,
    input  cidx_t             wr_cidx,
    output coord_t            vid_sx,
    output coord_t            vid_sy,
    output logic              vid_de,
    output logic              vid_frame,
    output logic [2*CHAN_W-1:0] vid_r,    // 8-bit channels
    output logic [2*CHAN_W-1:0] vid_g,
    output logic [2*CHAN_W-1:0] vid_b
);

    coord_t   sx, sy;
    logic     de, frame, line;
    logic     rd_req;
    fb_addr_t rd_addr;
    cidx_t    rd_data;
    logic     mem_we;
    fb_addr_t mem_waddr, mem_raddr;
    cidx_t    mem_wdata, mem_rdata;
    cidx_t    lb_cidx;   // aligned with current sx via lookahead
    colr_t    colr;      // one cycle behind, matches the _d signals
    coord_t   sx_d, sy_d;
    logic     de_d, frame_d;

    display_timing u_timing (.clk_pix, .rst_n, .sx, .sy, .de, .frame, .line);

    fb_arbiter u_arb (
        .clk_pix, .rst_n, .rd_req, .rd_addr, .rd_data, .wr_stb, .wr_addr, .wr_cidx,
        .mem_we, .mem_waddr, .mem_wdata, .mem_raddr, .mem_rdata
    );

    fb_bram u_bram (
        .clk_pix, .we(mem_we), .waddr(mem_waddr), .wdata(mem_wdata),
        .raddr(mem_raddr), .rdata(mem_rdata)
    );

    linebuffer_scaled u_lb (
        .clk_pix, .rst_n, .sx, .sy, .line, .rd_req, .rd_addr, .rd_data, .cidx(lb_cidx)
    );

    clut_grey u_clut (.clk_pix, .cidx(lb_cidx), .colr);

    // match the palette register stage
    always_ff @(posedge clk_pix) begin
        sx_d <= sx;
        sy_d <= sy;
    end

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            de_d    <= 1'b0;
            frame_d <= 1'b0;
        end else begin
            de_d    <= de;
            frame_d <= frame;
        end
    end

    // output stage, colour forced to black in blanking
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            vid_sx    <= '0;
            vid_sy    <= '0;
            vid_de    <= 1'b0;
            vid_frame <= 1'b0;
            vid_r     <= '0;
            vid_g     <= '0;
            vid_b     <= '0;
        end else begin
            vid_sx    <= sx_d;
            vid_sy    <= sy_d;
            vid_de    <= de_d;
            vid_frame <= frame_d;
            vid_r <= de_d ? {2{colr[3*CHAN_W-1 -: CHAN_W]}} : '0;  // nibble doubled
            vid_g <= de_d ? {2{colr[2*CHAN_W-1 -: CHAN_W]}} : '0;
            vid_b <= de_d ? {2{colr[CHAN_W-1 -: CHAN_W]}} : '0;
        end
    end

endmodule

//--- design/fb_pkg.sv
/* shared constants and types for the scaled framebuffer display
   import with fb_pkg::* in each module header */
package fb_pkg;

    // display timing, custom small mode
    localparam int H_ACTIVE = 64;   // visible columns
    localparam int H_TOTAL  = 80;   // incl 16 blanking columns
    localparam int V_ACTIVE = 48;   // visible lines
    localparam int V_TOTAL  = 54;   // incl 6 blanking lines

    // counters start in blanking, at negative values
    localparam int H_START = H_ACTIVE - H_TOTAL;  // -16
    localparam int V_START = V_ACTIVE - V_TOTAL;  // -6

    // framebuffer geometry
    localparam int FB_WIDTH  = 16;                    // source columns
    localparam int FB_HEIGHT = 12;                    // source rows
    localparam int FB_SCALE  = 4;                     // magnification, both axes
    localparam int FB_PIXELS = FB_WIDTH * FB_HEIGHT;  // 192 entries

    // colour widths
    localparam int CIDX_W = 4;  // colour index bits
    localparam int CHAN_W = 4;  // bits per palette channel

    // palette contents, 12-bit hex per line
    localparam string PAL_FILE = "design/grey16.mem";

    // signed screen coordinate, negative in blanking
    typedef logic signed [15:0] coord_t;

    // framebuffer address, row * FB_WIDTH + column
    typedef logic [7:0] fb_addr_t;

    // colour index as stored in framebuffer and linebuffer
    typedef logic [CIDX_W-1:0] cidx_t;

    // palette entry {r, g, b}
    typedef logic [3*CHAN_W-1:0] colr_t;

    // source column within one linebuffer bank
    typedef logic [3:0] lb_col_t;

endpackage

//--- design/grey16.mem
// one 12-bit {r,g,b} colour per line, grey ramp for indices 0 to 15
000
111
222
333
444
555
666
777
888
999
aaa
bbb
ccc
ddd
eee
fff

//--- design/linebuffer_scaled.sv
/* two-bank line store between the framebuffer and the screen
   fills the next source row during the last copy of the current one, replays it 4x4 */
`timescale 1ns/1ps

module linebuffer_scaled import fb_pkg::*; (
    input  logic     clk_pix,
    input  logic     rst_n,
    input  coord_t   sx,       // current screen position
    input  coord_t   sy,
    input  logic     line,     // start of line strobe
    output logic     rd_req,   // framebuffer read, every other cycle at most
    output fb_addr_t rd_addr,
    input  cidx_t    rd_data,  // two cycles after rd_req
    output cidx_t    cidx      // index for the pixel at the next sx
);

    localparam int ROW_W = $clog2(FB_HEIGHT);
    localparam int REP_W = $clog2(FB_SCALE);

    localparam lb_col_t         COL_LAST = lb_col_t'(FB_WIDTH - 1);
    localparam logic [ROW_W-1:0] ROW_LAST = ROW_W'(FB_HEIGHT - 1);
    localparam logic [REP_W-1:0] REP_LAST = REP_W'(FB_SCALE - 1);
    localparam coord_t          SY_PRE   = coord_t'(-1);  // blanking line before row 0

    typedef enum logic {IDLE, FETCH} fill_state_t;

    fill_state_t      state;
    logic             rd_phase;   // high on the spacer cycle
    lb_col_t          fetch_col;  // column of the next read
    logic [ROW_W-1:0] fill_row;   // source row being fetched
    logic [REP_W-1:0] rep_cnt;    // screen line within a source row
    logic             swap_pend;  // fill done this line, swap at next strobe
    logic             rd_bank;    // bank shown on screen
    logic             fill_go;
    logic [1:0]       tag_vld;    // read in flight, one bit per latency cycle
    lb_col_t          tag_col [2];
    coord_t           sx_ahead;
    lb_col_t          out_col;

    // two banks of one source row each
    cidx_t lb_mem [2][FB_WIDTH];

    // row 0 at line -1, then on the last repeat of each row, none after row 11
    assign fill_go = line && ((sy == SY_PRE)
                     || (sy >= 0 && rep_cnt == REP_LAST && fill_row != ROW_LAST));

    // reads on even phase only
    assign rd_req  = (state == FETCH) && !rd_phase;
    assign rd_addr = fb_addr_t'(fill_row * FB_WIDTH + fetch_col);

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            rd_phase  <= 1'b0;
            fetch_col <= '0;
            fill_row  <= '0;
            rep_cnt   <= '0;
            swap_pend <= 1'b0;
            rd_bank   <= 1'b0;
        end else begin
            if (line) begin
                // sync the repeat count to the pre-frame line
                rep_cnt <= (sy == SY_PRE || rep_cnt == REP_LAST) ? '0 : rep_cnt + 1'b1;
            end
            if (line && swap_pend) begin
                rd_bank   <= ~rd_bank;  // freshly filled bank goes live
                swap_pend <= 1'b0;
            end
            if (state == FETCH) begin
                rd_phase <= ~rd_phase;
                if (!rd_phase) begin
                    fetch_col <= fetch_col + 1'b1;
                    if (fetch_col == COL_LAST) begin
                        state <= IDLE;  // last read issued
                    end
                end
            end
            if (fill_go) begin
                state     <= FETCH;
                rd_phase  <= 1'b0;
                fetch_col <= '0;
                fill_row  <= (sy == SY_PRE) ? '0 : fill_row + 1'b1;
                swap_pend <= 1'b1;
            end
        end
    end

    // column tag follows each read through the two-cycle latency
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            tag_vld <= '0;
        end else begin
            tag_vld <= {tag_vld[0], rd_req};
        end
    end

    always_ff @(posedge clk_pix) begin
        tag_col[0] <= fetch_col;
        tag_col[1] <= tag_col[0];
    end

    // returned index lands in the hidden bank
    always_ff @(posedge clk_pix) begin
        if (tag_vld[1]) begin
            lb_mem[~rd_bank][tag_col[1]] <= rd_data;
        end
    end

    // look one pixel ahead so cidx lines up with the next sx
    always_comb begin
        sx_ahead = sx + coord_t'(1);
        out_col  = lb_col_t'(sx_ahead / coord_t'(FB_SCALE));  // 64 wraps to 0, in blanking
    end

    always_ff @(posedge clk_pix) begin
        cidx <= lb_mem[rd_bank][out_col];
    end

    // a fill started one line earlier must have drained before its bank is shown
    a_fill_done_at_swap : assert property (
        @(posedge clk_pix) disable iff (!rst_n)
        (line && swap_pend) |-> (state == IDLE && tag_vld == 2'b00)
    ) else $error("linebuffer_scaled: bank swap before fill complete");

endmodule

//--- fb_display.f
design/fb_pkg.sv
design/display_timing.sv
design/fb_bram.sv
design/fb_arbiter.sv
design/linebuffer_scaled.sv
design/clut_grey.sv
design/fb_display_top.sv
sim/tb_fb_display.sv

//--- run_sim.sh
#!/bin/sh
# build and run the framebuffer display testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
FAIL_MSG="FAIL: see errors above"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_fb_display -f fb_display.f \
    --Mdir obj_dir -o tb_fb_display
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_fb_display > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "$FAIL_MSG" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation passed"
exit 0

//--- sim/tb_fb_display.sv
/* testbench for the scaled framebuffer display, random pixel writes from a fixed seed
   every output pixel is predicted from a framebuffer model kept here */
`timescale 1ns/1ps

module tb_fb_display import fb_pkg::*; ();

    localparam int FRAME_CYCLES  = H_TOTAL * V_TOTAL;    // 4320
    localparam int ACTIVE_CYCLES = H_ACTIVE * V_ACTIVE;  // 3072
    localparam int CONTEND_WRITES = 300;                 // spans about ten lines

    // about eight frames of tests, rounded up to twelve
    localparam longint WATCHDOG_NS = 64'd12 * FRAME_CYCLES * 100;

    logic       clk_pix;
    logic       rst_n;
    logic       wr_stb;
    fb_addr_t   wr_addr;
    cidx_t      wr_cidx;
    coord_t     vid_sx;
    coord_t     vid_sy;
    logic       vid_de;
    logic       vid_frame;
    logic [7:0] vid_r;
    logic [7:0] vid_g;
    logic [7:0] vid_b;

    cidx_t  model [FB_PIXELS];  // what the screen should show
    integer seed;
    int     test_errs;          // errors in the running test
    int     pass_cnt;
    int     fail_cnt;

    fb_display_top dut (
        .clk_pix, .rst_n, .wr_stb, .wr_addr, .wr_cidx,
        .vid_sx, .vid_sy, .vid_de, .vid_frame, .vid_r, .vid_g, .vid_b
    );

    initial clk_pix = 1'b0;
    always #50 clk_pix = ~clk_pix;  // 100 ns period

    function automatic int unsigned rand_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    // one strobe, then one idle cycle, model updated at issue
    task automatic write_pixel(input fb_addr_t addr, input cidx_t ci);
        @(posedge clk_pix);
        #5;
        wr_stb      = 1'b1;
        wr_addr     = addr;
        wr_cidx     = ci;
        model[addr] = ci;
        @(posedge clk_pix);
        #5;
        wr_stb = 1'b0;
    endtask

    task automatic wait_vid_frame();
        do begin
            @(negedge clk_pix);  // outputs settled mid-cycle
        end while (!vid_frame);
    endtask

    // walks one whole frame from its vid_frame pulse
    task automatic scan_frame(input bit check_colour);
        coord_t     exp_sx;
        coord_t     exp_sy;
        int         de_cnt;
        int         idx;
        logic [7:0] exp_ch;
        exp_sx = coord_t'(H_START);
        exp_sy = coord_t'(V_START);
        de_cnt = 0;
        wait_vid_frame();
        for (int i = 0; i < FRAME_CYCLES; i++) begin
            if (i > 0) begin
                @(negedge clk_pix);
            end
            assert (vid_sx == exp_sx && vid_sy == exp_sy) else begin
                $display("Mismatch at %0t: position expected (%0d,%0d) got (%0d,%0d)",
                         $time, exp_sx, exp_sy, vid_sx, vid_sy);
                test_errs++;
            end
            assert (vid_frame == (i == 0)) else begin
                $display("Mismatch at %0t: at (%0d,%0d) vid_frame expected %0b got %0b",
                         $time, exp_sx, exp_sy, (i == 0), vid_frame);
                test_errs++;
            end
            assert (vid_de == (exp_sx >= 0 && exp_sy >= 0)) else begin
                $display("Mismatch at %0t: at (%0d,%0d) vid_de expected %0b got %0b",
                         $time, exp_sx, exp_sy, (exp_sx >= 0 && exp_sy >= 0), vid_de);
                test_errs++;
            end
            if (vid_de) begin
                de_cnt++;
            end
            if (!vid_de) begin
                // black in blanking
                assert (vid_r == 8'h00 && vid_g == 8'h00 && vid_b == 8'h00) else begin
                    $display("Mismatch at %0t: at (%0d,%0d) expected black got %h %h %h",
                             $time, exp_sx, exp_sy, vid_r, vid_g, vid_b);
                    test_errs++;
                end
            end else if (check_colour && exp_sx >= 0 && exp_sy >= 0) begin
                idx    = (exp_sy / FB_SCALE) * FB_WIDTH + exp_sx / FB_SCALE;
                exp_ch = {model[idx], model[idx]};  // grey ramp, nibble doubled
                assert (vid_r == exp_ch && vid_g == exp_ch && vid_b == exp_ch) else begin
                    $display("Mismatch at %0t: at (%0d,%0d) expected %h got %h %h %h",
                             $time, exp_sx, exp_sy, exp_ch, vid_r, vid_g, vid_b);
                    test_errs++;
                end
            end
            // next raster position
            if (exp_sx == coord_t'(H_ACTIVE - 1)) begin
                exp_sx = coord_t'(H_START);
                if (exp_sy == coord_t'(V_ACTIVE - 1)) begin
                    exp_sy = coord_t'(V_START);
                end else begin
                    exp_sy = exp_sy + coord_t'(1);
                end
            end else begin
                exp_sx = exp_sx + coord_t'(1);
            end
        end
        assert (de_cnt == ACTIVE_CYCLES) else begin
            $display("Mismatch at %0t: vid_de high for %0d cycles, expected %0d",
                     $time, de_cnt, ACTIVE_CYCLES);
            test_errs++;
        end
    endtask

    task automatic end_test(input string name);
        if (test_errs == 0) begin
            pass_cnt++;
            $display("test %s: passed", name);
        end else begin
            fail_cnt++;
            $display("test %s: failed with %0d errors", name, test_errs);
        end
        test_errs = 0;
    endtask

    initial begin
        cidx_t solid;
        seed      = 32'hfc9e_585a;
        rst_n     = 1'b0;
        wr_stb    = 1'b0;
        wr_addr   = '0;
        wr_cidx   = '0;
        test_errs = 0;
        pass_cnt  = 0;
        fail_cnt  = 0;
        repeat (16) @(posedge clk_pix);
        #5;
        rst_n = 1'b1;

        // outputs still at reset values before the pipeline fills
        @(negedge clk_pix);
        assert (!vid_de && !vid_frame) else begin
            $display("Mismatch at %0t: vid_de %0b vid_frame %0b, expected both low after reset",
                     $time, vid_de, vid_frame);
            test_errs++;
        end
        scan_frame(1'b0);  // framebuffer still undefined
        @(negedge clk_pix);
        assert (vid_frame) else begin
            $display("Mismatch at %0t: no vid_frame %0d cycles after the last one",
                     $time, FRAME_CYCLES);
            test_errs++;
        end
        end_test("reset and blanking");

        solid = cidx_t'(rand_below(16));
        for (int a = 0; a < FB_PIXELS; a++) begin
            write_pixel(fb_addr_t'(a), solid);
        end
        scan_frame(1'b1);
        end_test("solid fill");

        for (int a = 0; a < FB_PIXELS; a++) begin
            write_pixel(fb_addr_t'(a), cidx_t'(rand_below(16)));
        end
        scan_frame(1'b1);  // 4x replication both ways
        end_test("random image");

        // writes land on top of the row fills at lines 3 and 7
        wait_vid_frame();
        do begin
            @(negedge clk_pix);
        end while (!vid_de);
        for (int n = 0; n < CONTEND_WRITES; n++) begin
            write_pixel(fb_addr_t'(rand_below(FB_PIXELS)), cidx_t'(rand_below(16)));
            if (rand_below(2) == 1) begin
                @(posedge clk_pix);  // extra idle cycle now and then
            end
        end
        scan_frame(1'b1);
        end_test("contention");

        scan_frame(1'b1);
        end_test("coordinate alignment");

        $display("tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // stops a run that never reaches the end
    initial begin
        #(WATCHDOG_NS);
        $display("simulation timed out after %0d ns, the tests did not finish", WATCHDOG_NS);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule
